// ==== common/indicator_pkg.sv ====
// ********************
// shared widths and types for the indicator LED controller
// vectors are sized for the largest build of 8 bits and 16 channels
// modules narrow them with their own RESOLUTION and CHANNELS parameters
// ********************

`default_nettype none

package indicator_pkg;

	localparam int MAX_RESOLUTION = 8; // widest PWM resolution any module may be built with
	localparam int MAX_CHANNELS = 16; // most channels a command can address
	localparam int CHANNEL_W = $clog2(MAX_CHANNELS); // bits in a channel number

	// brightness level as the host writes it
	typedef logic [MAX_RESOLUTION-1:0] level_t;

	// one extra bit so that full on at 2^RESOLUTION still fits
	typedef logic [MAX_RESOLUTION:0] duty_t;

	// channel number carried by a command
	typedef logic [CHANNEL_W-1:0] channel_t;

	// per-channel operating mode
	typedef enum logic [1:0] {
		mode_off = 2'd0, // output held low
		mode_on = 2'd1, // output held high for the whole frame
		mode_fixed = 2'd2, // duty taken straight from the level register
		mode_breathe = 2'd3 // duty follows the phase-shifted triangle ramp
	} ind_mode_e;

endpackage

`default_nettype wire

// ==== common/duty_bus_if.sv ====
// ********************
// duty and timing bus from the ramp to the PWM bank
// tick and duty come from the ramp side and frame_start from the bank side
// CHANNELS must match on both ends
// ********************

`timescale 1ns/1ps
`default_nettype none

interface duty_bus_if
	import indicator_pkg::*;
#(
	parameter int CHANNELS = 8
) ();

	logic tick; // one cycle in every PRESCALE cycles
	duty_t duty [CHANNELS]; // registered duty per channel
	logic frame_start; // pulses on the tick that wraps the frame counter

	// the ramp makes the timebase and the duties and watches frame boundaries
	modport ramp_side (
		output tick,
		output duty,
		input frame_start
	);

	// the bank counts ticks into frames and latches duties at each boundary
	modport bank_side (
		input tick,
		input duty,
		output frame_start
	);

endinterface

`default_nettype wire

// ==== src/indicator_cmd_decode.sv ====
// ********************
// command decode with one mode and level register per channel
// commands are single-cycle strobes and every strobe is taken
// channel numbers of CHANNELS or more are dropped
// ********************

`timescale 1ns/1ps
`default_nettype none

module indicator_cmd_decode
	import indicator_pkg::*;
#(
	parameter int CHANNELS = 8
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic cmd_valid, // one-cycle command strobe
	input channel_t cmd_channel, // target channel of the command
	input ind_mode_e cmd_mode, // new mode for that channel
	input level_t cmd_level, // new level for that channel
	output ind_mode_e mode [CHANNELS], // current mode of each channel
	output level_t level [CHANNELS] // current level of each channel
);

	logic [CHANNELS-1:0] hit; // one-hot write enable per channel

	// each channel compares its own number so out-of-range commands match nothing
	always_comb begin
		for (int i = 0; i < CHANNELS; i++) begin
			hit[i] = cmd_valid && (cmd_channel == channel_t'(i));
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < CHANNELS; i++) begin
				mode[i] <= mode_off; // every channel starts dark
				level[i] <= '0;
			end
		end else begin
			for (int i = 0; i < CHANNELS; i++) begin
				if (hit[i]) begin
					mode[i] <= cmd_mode; // visible one cycle after the strobe
					level[i] <= cmd_level; // mode and level are always written together
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/breath_ramp.sv ====
// ********************
// timebase and duty computation for every channel
// the ramp steps once per STEP_FRAMES frames and only counts while ramp_enable is high
// fixed mode uses the low RESOLUTION bits of the level
// duties are registered one cycle after the mode and level registers
// ********************

`timescale 1ns/1ps
`default_nettype none

module breath_ramp
	import indicator_pkg::*;
#(
	parameter int CHANNELS = 8,
	parameter int RESOLUTION = 8,
	parameter int PRESCALE = 7,
	parameter int STEP_FRAMES = 4
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic ramp_enable, // lets the ramp advance
	input ind_mode_e mode [CHANNELS], // per-channel mode from decode
	input level_t level [CHANNELS], // per-channel level from decode
	duty_bus_if.ramp_side bus
);

	localparam int MAX = (1 << RESOLUTION) - 1; // brightest triangle value
	localparam int SPAN = 2 * MAX; // one full up and down sweep of the ramp
	localparam int PHASE_STEP = SPAN / CHANNELS; // ramp offset between neighbouring channels
	localparam int PRESC_W = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;
	localparam int STEP_W = (STEP_FRAMES > 1) ? $clog2(STEP_FRAMES) : 1;
	localparam int POS_W = RESOLUTION + 1; // holds 0 to SPAN-1
	localparam int ARG_W = RESOLUTION + 2; // holds a position plus an offset before the wrap
	localparam duty_t FULL_ON = duty_t'(1 << RESOLUTION); // high for the whole frame
	localparam level_t LEVEL_MASK = level_t'(MAX); // keeps fixed levels inside the frame

	logic [PRESC_W-1:0] presc_cnt; // cycles since the last tick
	logic [STEP_W-1:0] step_cnt; // enabled frames since the last ramp step
	logic [POS_W-1:0] ramp_pos; // shared ramp position before the phase offset
	logic [ARG_W-1:0] phase_sum [CHANNELS]; // position plus this channel's offset
	logic [ARG_W-1:0] phase_arg [CHANNELS]; // the same value folded back into one sweep
	level_t tri_level [CHANNELS]; // triangle brightness of each channel
	duty_t duty_q [CHANNELS]; // registered duty handed to the bank

	assign bus.tick = (presc_cnt == PRESC_W'(PRESCALE - 1)); // last cycle of each prescale period

	always_ff @(posedge clk) begin
		if (reset) begin
			presc_cnt <= '0;
		end else if (bus.tick) begin
			presc_cnt <= '0; // restart the prescale period
		end else begin
			presc_cnt <= presc_cnt + 1'b1;
		end
	end

	// frames are only counted while enabled so a pause freezes the divider too
	always_ff @(posedge clk) begin
		if (reset) begin
			step_cnt <= '0;
			ramp_pos <= '0;
		end else if (ramp_enable && bus.frame_start) begin
			if (step_cnt == STEP_W'(STEP_FRAMES - 1)) begin
				step_cnt <= '0;
				if (ramp_pos == POS_W'(SPAN - 1)) begin
					ramp_pos <= '0; // one full breath done
				end else begin
					ramp_pos <= ramp_pos + 1'b1;
				end
			end else begin
				step_cnt <= step_cnt + 1'b1;
			end
		end
	end

	for (genvar i = 0; i < CHANNELS; i++) begin : g_chan
		// the offset is below SPAN so a single subtract wraps the sum
		assign phase_sum[i] = ARG_W'(ramp_pos) + ARG_W'(i * PHASE_STEP);
		assign phase_arg[i] = (phase_sum[i] >= ARG_W'(SPAN)) ? phase_sum[i] - ARG_W'(SPAN)
			: phase_sum[i];
		assign tri_level[i] = (phase_arg[i] <= ARG_W'(MAX)) ? level_t'(phase_arg[i])
			: level_t'(ARG_W'(SPAN) - phase_arg[i]); // falling half of the triangle

		always_ff @(posedge clk) begin
			if (reset) begin
				duty_q[i] <= '0;
			end else begin
				case (mode[i])
					mode_off: duty_q[i] <= '0;
					mode_on: duty_q[i] <= FULL_ON;
					mode_fixed: duty_q[i] <= duty_t'(level[i] & LEVEL_MASK);
					mode_breathe: duty_q[i] <= duty_t'(tri_level[i]);
					default: duty_q[i] <= '0;
				endcase
			end
		end

		assign bus.duty[i] = duty_q[i];
	end

endmodule

`default_nettype wire

// ==== pwm/pwm_channel.sv ====
// ********************
// one PWM output with a duty latched at the frame boundary
// the output is registered and trails the shared count by one cycle
// a duty of 2^RESOLUTION or more keeps the output high for the whole frame
// ********************

`timescale 1ns/1ps
`default_nettype none

module pwm_channel
	import indicator_pkg::*;
#(
	parameter int RESOLUTION = 8
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic frame_start, // loads the next duty
	input level_t count, // shared frame position from the bank
	input duty_t duty, // duty offered by the ramp
	output logic pwm // LED drive
);

	duty_t duty_q; // duty in force for the current frame

	always_ff @(posedge clk) begin
		if (reset) begin
			duty_q <= '0;
			pwm <= 1'b0;
		end else begin
			if (frame_start) begin
				duty_q <= duty; // duty only changes between frames
			end
			pwm <= (duty_t'(count) < duty_q); // leading pulse with no special case for full on
		end
	end

endmodule

`default_nettype wire

// ==== pwm/pwm_bank.sv ====
// ********************
// PWM bank with one frame counter shared by all channels
// a frame lasts 2^RESOLUTION ticks
// frame_start is combinational from the tick and the counter
// ********************

`timescale 1ns/1ps
`default_nettype none

module pwm_bank
	import indicator_pkg::*;
#(
	parameter int CHANNELS = 8,
	parameter int RESOLUTION = 8
) (
	input wire logic clk,
	input wire logic reset,
	duty_bus_if.bank_side bus,
	output logic [CHANNELS-1:0] pwm_out // one LED drive per channel
);

	localparam int MAX = (1 << RESOLUTION) - 1; // last count of a frame

	logic [RESOLUTION-1:0] frame_cnt; // ticks into the current frame
	level_t count; // frame position widened for the channels

	assign bus.frame_start = bus.tick && (frame_cnt == RESOLUTION'(MAX)); // this tick wraps
	assign count = level_t'(frame_cnt);

	always_ff @(posedge clk) begin
		if (reset) begin
			frame_cnt <= '0;
		end else if (bus.tick) begin
			frame_cnt <= frame_cnt + 1'b1; // wraps to zero by its width
		end
	end

	// every channel sees the same count so all pulses start together
	for (genvar i = 0; i < CHANNELS; i++) begin : g_pwm
		pwm_channel #(
			.RESOLUTION(RESOLUTION)
		) u_channel (
			.clk(clk),
			.reset(reset),
			.frame_start(bus.frame_start),
			.count(count),
			.duty(bus.duty[i]),
			.pwm(pwm_out[i])
		);
	end

endmodule

`default_nettype wire

// ==== src/indicator_top.sv ====
// ********************
// multichannel indicator LED controller
// CHANNELS up to 16 and RESOLUTION up to 8
// a command needs 3 cycles of lead before a frame_start to land in that frame
// ********************

`timescale 1ns/1ps
`default_nettype none

module indicator_top
	import indicator_pkg::*;
#(
	parameter int CHANNELS = 8,
	parameter int RESOLUTION = 8,
	parameter int PRESCALE = 7,
	parameter int STEP_FRAMES = 4
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic cmd_valid, // one-cycle command strobe
	input channel_t cmd_channel, // channel the command addresses
	input ind_mode_e cmd_mode, // requested mode
	input level_t cmd_level, // requested level
	input wire logic ramp_enable, // low pauses the breathing ramp
	output logic [CHANNELS-1:0] pwm_out, // LED drives
	output logic frame_start // one cycle at each PWM frame boundary
);

	ind_mode_e mode [CHANNELS]; // decoded mode per channel
	level_t level [CHANNELS]; // decoded level per channel

	duty_bus_if #(
		.CHANNELS(CHANNELS)
	) duty_bus ();

	assign frame_start = duty_bus.frame_start;

	indicator_cmd_decode #(
		.CHANNELS(CHANNELS)
	) u_decode (
		.clk(clk),
		.reset(reset),
		.cmd_valid(cmd_valid),
		.cmd_channel(cmd_channel),
		.cmd_mode(cmd_mode),
		.cmd_level(cmd_level),
		.mode(mode),
		.level(level)
	);

	breath_ramp #(
		.CHANNELS(CHANNELS),
		.RESOLUTION(RESOLUTION),
		.PRESCALE(PRESCALE),
		.STEP_FRAMES(STEP_FRAMES)
	) u_ramp (
		.clk(clk),
		.reset(reset),
		.ramp_enable(ramp_enable),
		.mode(mode),
		.level(level),
		.bus(duty_bus.ramp_side)
	);

	pwm_bank #(
		.CHANNELS(CHANNELS),
		.RESOLUTION(RESOLUTION)
	) u_bank (
		.clk(clk),
		.reset(reset),
		.bus(duty_bus.bank_side),
		.pwm_out(pwm_out)
	);

endmodule

`default_nettype wire

// ==== verif/tb_indicator.sv ====
// ********************
// testbench for indicator_top built with 4 channels, 4-bit resolution and prescale 3
// one PWM frame is 48 clock cycles
// commands go out right after a frame_start so each lands in the next frame
// a frame's high count ends one cycle after its closing frame_start
// ********************

`timescale 1ns/1ps
`default_nettype none

module tb_indicator
	import indicator_pkg::*;
();

	localparam int CHANNELS = 4;
	localparam int RESOLUTION = 4;
	localparam int PRESCALE = 3;
	localparam int STEP_FRAMES = 2;
	localparam int MAX_LEVEL = (1 << RESOLUTION) - 1; // top of the triangle
	localparam int FRAME_CYCLES = (1 << RESOLUTION) * PRESCALE; // 48 cycles per frame
	localparam int CLK_HALF = 20; // 40 ns clock period
	localparam int DRIVE_DELAY = 2; // inputs change this long after the rising edge
	localparam int TOTAL_FRAMES = 310; // frames run by all six tests together
	localparam int WATCHDOG_NS = (TOTAL_FRAMES + 4) * FRAME_CYCLES * 2 * CLK_HALF;

	logic clk;
	logic reset;
	logic cmd_valid;
	channel_t cmd_channel;
	ind_mode_e cmd_mode;
	level_t cmd_level;
	logic ramp_enable;
	logic [CHANNELS-1:0] pwm_out;
	logic frame_start;

	ind_mode_e model_mode [CHANNELS]; // mode table as the host has written it
	int model_level [CHANNELS]; // level table as the host has written it
	int model_pos; // ramp position before the phase offsets
	int model_step; // enabled frames since the last ramp step
	int exp_duty [CHANNELS]; // duty in force for the frame being counted
	int next_duty [CHANNELS]; // duty latched at the last frame_start
	int high_cnt [CHANNELS]; // high cycles seen so far in the counted frame
	int cycle_cnt; // cycles since reset was released
	int last_fs_cycle; // cycle of the previous frame_start
	logic close_pending; // the next sample ends the counted frame
	logic fs_now; // frame_start was high in the latest sample
	logic ren_q; // ramp_enable value for the coming drives
	logic [31:0] lfsr_state;
	string test_name;
	int test_checks;
	int test_fails;
	int total_checks;
	int total_fails;
	int tests_run;

	indicator_top #(
		.CHANNELS(CHANNELS),
		.RESOLUTION(RESOLUTION),
		.PRESCALE(PRESCALE),
		.STEP_FRAMES(STEP_FRAMES)
	) u_dut (
		.clk(clk),
		.reset(reset),
		.cmd_valid(cmd_valid),
		.cmd_channel(cmd_channel),
		.cmd_mode(cmd_mode),
		.cmd_level(cmd_level),
		.ramp_enable(ramp_enable),
		.pwm_out(pwm_out),
		.frame_start(frame_start)
	);

	always #(CLK_HALF) clk = ~clk;

	// galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic int take_bits(input int n);
		int v;
		v = 0;
		for (int b = 0; b < n; b++) begin
			v = (v << 1) | int'(lfsr_state[0]); // one register step per bit taken
			lfsr_state = lfsr_step(lfsr_state);
		end
		return v;
	endfunction

	// duty a channel should get from the current tables and ramp position
	function automatic int expected_duty(input int ch);
		int arg;
		int tri_v;
		arg = (model_pos + ch * ((2 * MAX_LEVEL) / CHANNELS)) % (2 * MAX_LEVEL);
		tri_v = (arg <= MAX_LEVEL) ? arg : 2 * MAX_LEVEL - arg; // fold the falling half
		case (model_mode[ch])
			mode_on: return 1 << RESOLUTION;
			mode_fixed: return model_level[ch];
			mode_breathe: return tri_v;
			default: return 0;
		endcase
	endfunction

	task automatic check_value(input string what, input int expected, input int actual);
		test_checks++;
		assert (expected == actual) else begin
			$display("MISMATCH %s %s expected %0d actual %0d", test_name, what, expected, actual);
			test_fails++;
		end
	endtask

	task automatic close_frame();
		for (int c = 0; c < CHANNELS; c++) begin
			check_value($sformatf("ch%0d high cycles", c), exp_duty[c] * PRESCALE, high_cnt[c]);
			exp_duty[c] = next_duty[c]; // the frame that just began
			high_cnt[c] = 0;
		end
		close_pending = 1'b0;
	endtask

	// outputs are read at the falling edge where they are settled
	task automatic sample_cycle();
		@(negedge clk);
		cycle_cnt++;
		for (int c = 0; c < CHANNELS; c++) begin
			if (pwm_out[c]) begin
				high_cnt[c]++;
			end
		end
		if (close_pending) begin
			close_frame(); // this cycle still showed the last slot of the old frame
		end
		fs_now = frame_start;
		if (frame_start) begin
			check_value("frame_start spacing", FRAME_CYCLES, cycle_cnt - last_fs_cycle);
			last_fs_cycle = cycle_cnt;
			for (int c = 0; c < CHANNELS; c++) begin
				next_duty[c] = expected_duty(c); // uses the position before this step
			end
			if (ramp_enable) begin
				if (model_step == STEP_FRAMES - 1) begin
					model_step = 0;
					model_pos = (model_pos + 1) % (2 * MAX_LEVEL);
				end else begin
					model_step++;
				end
			end
			close_pending = 1'b1;
		end
	endtask

	task automatic drive_cycle(input logic valid, input int ch, input int mode, input int lvl);
		@(posedge clk);
		#(DRIVE_DELAY);
		cmd_valid = valid;
		cmd_channel = channel_t'(ch);
		cmd_mode = ind_mode_e'(mode);
		cmd_level = level_t'(lvl);
		ramp_enable = ren_q;
		if (valid && ch < CHANNELS) begin
			model_mode[ch] = ind_mode_e'(mode); // out-of-range channels change nothing
			model_level[ch] = lvl;
		end
		sample_cycle();
	endtask

	task automatic send_cmd(input int ch, input int mode, input int lvl);
		drive_cycle(1'b1, ch, mode, lvl);
	endtask

	task automatic idle_cycle();
		drive_cycle(1'b0, 0, 0, 0);
	endtask

	// returns in the sample that saw frame_start
	task automatic wait_frame();
		idle_cycle();
		while (!fs_now) begin
			idle_cycle();
		end
	endtask

	task automatic finish_test();
		wait_frame();
		idle_cycle(); // ends the frame carrying the last commands
		$display("test %-10s %0d checks, %0d failed", test_name, test_checks, test_fails);
		tests_run++;
		total_checks += test_checks;
		total_fails += test_fails;
		test_checks = 0;
		test_fails = 0;
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the run took longer than its %0d frames allow", TOTAL_FRAMES);
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		int lvl;
		int n;
		int ch;
		int mode;
		clk = 1'b0;
		reset = 1'b1;
		cmd_valid = 1'b0;
		cmd_channel = '0;
		cmd_mode = mode_off;
		cmd_level = '0;
		ramp_enable = 1'b0;
		ren_q = 1'b0;
		for (int c = 0; c < CHANNELS; c++) begin
			model_mode[c] = mode_off;
			model_level[c] = 0;
			exp_duty[c] = 0;
			next_duty[c] = 0;
			high_cnt[c] = 0;
		end
		model_pos = 0;
		model_step = 0;
		close_pending = 1'b0;
		fs_now = 1'b0;
		lfsr_state = 32'hbf93_cc11;
		test_checks = 0;
		test_fails = 0;
		total_checks = 0;
		total_fails = 0;
		tests_run = 0;
		repeat (2) @(posedge clk);
		#(DRIVE_DELAY);
		reset = 1'b0;
		cycle_cnt = 0; // frame_start spacing counts from here
		last_fs_cycle = 0;
		sample_cycle();

		test_name = "reset_idle"; // all channels off, so every count must be zero
		repeat (2) wait_frame();
		finish_test();

		test_name = "fixed";
		for (int k = 0; k < 10; k++) begin
			for (int c = 0; c < CHANNELS; c++) begin
				lvl = (c == k % CHANNELS) ? 0 : take_bits(RESOLUTION); // one dark channel a frame
				send_cmd(c, mode_fixed, lvl);
			end
			wait_frame();
		end
		finish_test();

		test_name = "on_off";
		for (int c = 0; c < CHANNELS; c++) begin
			send_cmd(c, mode_on, take_bits(RESOLUTION));
		end
		wait_frame();
		send_cmd(4, mode_off, 0); // channels 4 and up do not exist
		send_cmd(9, mode_fixed, 3);
		send_cmd(15, mode_off, 0);
		wait_frame();
		for (int c = 0; c < CHANNELS; c++) begin
			send_cmd(c, mode_off, take_bits(RESOLUTION));
		end
		wait_frame();
		send_cmd(0, mode_on, 0);
		send_cmd(2, mode_fixed, 7);
		send_cmd(5, mode_on, 0);
		wait_frame();
		send_cmd(0, mode_off, 0);
		send_cmd(12, mode_fixed, 9);
		wait_frame();
		send_cmd(2, mode_off, 0);
		send_cmd(7, mode_on, 15);
		wait_frame();
		finish_test();

		test_name = "breathe"; // 70 frames is 35 ramp steps, more than one 30-step period
		ren_q = 1'b1;
		for (int c = 0; c < CHANNELS; c++) begin
			send_cmd(c, mode_breathe, take_bits(RESOLUTION));
		end
		repeat (70) wait_frame();
		finish_test();

		test_name = "freeze";
		ren_q = 1'b0; // duties must hold still
		repeat (8) wait_frame();
		ren_q = 1'b1; // and pick up from the same position
		repeat (8) wait_frame();
		finish_test();

		test_name = "random";
		for (int k = 0; k < 200; k++) begin
			if (take_bits(2) == 0) begin
				ren_q = ~ren_q; // toggles about one frame in four
			end
			n = take_bits(2);
			if (n == 0) begin
				idle_cycle();
			end
			for (int j = 0; j < n; j++) begin
				ch = take_bits(3); // reaches past the last channel on purpose
				mode = take_bits(2);
				lvl = take_bits(RESOLUTION);
				send_cmd(ch, mode, lvl);
			end
			wait_frame();
		end
		finish_test();

		$display("summary: %0d tests, %0d checks, %0d failed", tests_run, total_checks,
			total_fails);
		if (total_fails == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
common/indicator_pkg.sv
common/duty_bus_if.sv
src/indicator_cmd_decode.sv
src/breath_ramp.sv
pwm/pwm_channel.sv
pwm/pwm_bank.sv
src/indicator_top.sv
verif/tb_indicator.sv

// ==== Makefile ====
# Verilator build and run of the indicator LED controller testbench

SOURCES := $(shell cat tb.f)

.PHONY: run clean

run: obj_dir/Vtb_indicator
	./obj_dir/Vtb_indicator > sim.log 2>&1 || true
	cat sim.log
	grep -q "^NO ERRORS$$" sim.log

obj_dir/Vtb_indicator: tb.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_indicator -f tb.f -o Vtb_indicator

clean:
	rm -rf obj_dir sim.log
